/* Makefile */
# Verilator build and run of the chip IO testbench

SRCS := tb.f $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_chip_io
	@out=$$(./obj_dir/Vtb_chip_io); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

obj_dir/Vtb_chip_io: $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module tb_chip_io -f tb.f -o Vtb_chip_io

clean:
	rm -rf obj_dir

/* design/chip_io_config.svh */
/* Chip IO configuration
   Pad counts, JTAG pin map, GPIO register map and the TAP identification code */

`ifndef CHIP_IO_CONFIG_SVH
`define CHIP_IO_CONFIG_SVH

// Pad bank: muxed pads first, dedicated pads on top
`define CHIP_NUM_MIO      8
`define CHIP_NUM_DIO      4
`define CHIP_NUM_IO       12

// JTAG pin map, combined index
`define CHIP_PIN_JTAG_EN  4   // Strap, high selects JTAG
`define CHIP_PIN_TRST     5
`define CHIP_PIN_TCK      8   // DIO 0
`define CHIP_PIN_TMS      9   // DIO 1, also core CSB (active low)
`define CHIP_PIN_TDI      10  // DIO 2
`define CHIP_PIN_TDO      11  // DIO 3

// Core view of stolen pins while JTAG owns them, CSB parked high
`define CHIP_JTAG_TIEOFF  12'h200
`define CHIP_IO_CONNECT   12'hfff  // All pads bonded
`define CHIP_JTAG_IDCODE  32'h1c90_a3d3

// GPIO register map
`define REG_OUT           2'd0
`define REG_OE            2'd1
`define REG_INV           2'd2
`define REG_IN            2'd3

`define CHIP_TCK_SYNC     2  // Input synchronizer depth

`endif

/* design/chip_io_top.sv */
/* Chip IO top
   Padring, JTAG overlay mux, TAP and GPIO core */

`timescale 1ns/1ps
`default_nettype none

module chip_io_top (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  // Pads
  input  wire pad_pkg::pad_vec_t  pad_in_i,
  output pad_pkg::pad_vec_t       pad_out_o,
  output pad_pkg::pad_vec_t       pad_oe_o,
  // Register port
  input  wire logic               reg_we_i,
  input  wire pad_pkg::reg_addr_t reg_addr_i,
  input  wire pad_pkg::pad_vec_t  reg_wdata_i,
  output pad_pkg::pad_vec_t       reg_rdata_o,
  output logic                    jtag_active_o
);

  import pad_pkg::*;

  pad_vec_t core_out;
  pad_vec_t core_oe;
  pad_vec_t core_in;
  pad_vec_t inv;
  pad_vec_t ring_out;
  pad_vec_t ring_oe;
  pad_vec_t ring_in;

  logic tap_tck;
  logic tap_tms;
  logic tap_tdi;
  logic tap_trst_n;
  logic tap_tdo;
  logic tap_tdo_oe;

  //////////////////////////////////////////////////////////////////////
  // Padring
  //////////////////////////////////////////////////////////////////////

  padring padring_i (
    .clk_i      ( clk_i     ),
    .rst_i      ( rst_i     ),
    .pad_in_i   ( pad_in_i  ),
    .pad_out_o  ( pad_out_o ),
    .pad_oe_o   ( pad_oe_o  ),
    .ring_out_i ( ring_out  ),
    .ring_oe_i  ( ring_oe   ),
    .ring_in_o  ( ring_in   ),
    .inv_i      ( inv       )
  );

  //////////////////////////////////////////////////////////////////////
  // JTAG overlay and TAP
  //////////////////////////////////////////////////////////////////////

  jtag_overlay_mux jtag_overlay_mux_i (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .ring_in_i     ( ring_in       ),
    .ring_out_o    ( ring_out      ),
    .ring_oe_o     ( ring_oe       ),
    .core_out_i    ( core_out      ),
    .core_oe_i     ( core_oe       ),
    .core_in_o     ( core_in       ),
    .tap_tck_o     ( tap_tck       ),
    .tap_tms_o     ( tap_tms       ),
    .tap_tdi_o     ( tap_tdi       ),
    .tap_trst_n_o  ( tap_trst_n    ),
    .tap_tdo_i     ( tap_tdo       ),
    .tap_tdo_oe_i  ( tap_tdo_oe    ),
    .jtag_active_o ( jtag_active_o )
  );

  jtag_tap jtag_tap_i (
    .clk_i    ( clk_i      ),
    .rst_i    ( rst_i      ),
    .tck_i    ( tap_tck    ),
    .tms_i    ( tap_tms    ),
    .tdi_i    ( tap_tdi    ),
    .trst_n_i ( tap_trst_n ),
    .sample_i ( core_in    ),  // SAMPLE sees what the core sees
    .tdo_o    ( tap_tdo    ),
    .tdo_oe_o ( tap_tdo_oe )
  );

  //////////////////////////////////////////////////////////////////////
  // GPIO core
  //////////////////////////////////////////////////////////////////////

  gpio_core gpio_core_i (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .reg_we_i    ( reg_we_i    ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_rdata_o ( reg_rdata_o ),
    .core_in_i   ( core_in     ),
    .core_out_o  ( core_out    ),
    .core_oe_o   ( core_oe     ),
    .inv_o       ( inv         )
  );

endmodule : chip_io_top

`default_nettype wire

/* design/gpio_core.sv */
/* GPIO core
   Output, output enable and inversion registers with pad input read-back */

`timescale 1ns/1ps
`default_nettype none

`include "chip_io_config.svh"

module gpio_core (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  // Register port
  input  wire logic               reg_we_i,
  input  wire pad_pkg::reg_addr_t reg_addr_i,
  input  wire pad_pkg::pad_vec_t  reg_wdata_i,
  output pad_pkg::pad_vec_t       reg_rdata_o,
  // Pad side
  input  wire pad_pkg::pad_vec_t  core_in_i,
  output pad_pkg::pad_vec_t       core_out_o,
  output pad_pkg::pad_vec_t       core_oe_o,
  output pad_pkg::pad_vec_t       inv_o
);

  import pad_pkg::*;

  pad_vec_t out_q;
  pad_vec_t oe_q;
  pad_vec_t inv_q;

  //////////////////////////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q <= '0;
      oe_q  <= '0;  // All pads start as inputs
      inv_q <= '0;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        `REG_OUT: out_q <= reg_wdata_i;
        `REG_OE:  oe_q  <= reg_wdata_i;
        `REG_INV: inv_q <= reg_wdata_i;
        default: ;  // IN is read only
      endcase
    end
  end

  assign core_out_o = out_q;
  assign core_oe_o  = oe_q;
  assign inv_o      = inv_q;

  //////////////////////////////////////////////////////////////////////
  // Register reads
  //////////////////////////////////////////////////////////////////////

  // Same-cycle read, no wait states
  always_comb begin
    case (reg_addr_i)
      `REG_OUT: reg_rdata_o = out_q;
      `REG_OE:  reg_rdata_o = oe_q;
      `REG_INV: reg_rdata_o = inv_q;
      default:  reg_rdata_o = core_in_i;
    endcase
  end

  // Covers the synchronized pad inputs as well as the registers
  a_rdata_known: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !$isunknown(reg_rdata_o)
  ) else $error("gpio_core: read data unknown");

endmodule : gpio_core

`default_nettype wire

/* design/jtag_overlay_mux.sv */
/* JTAG overlay mux
   Latches the JTAG strap during reset and hands the JTAG pins to the TAP,
   feeding the core fixed tie-off values on those pins */

`timescale 1ns/1ps
`default_nettype none

`include "chip_io_config.svh"

module jtag_overlay_mux (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  // Padring side
  input  wire pad_pkg::pad_vec_t ring_in_i,
  output pad_pkg::pad_vec_t      ring_out_o,
  output pad_pkg::pad_vec_t      ring_oe_o,
  // Core side
  input  wire pad_pkg::pad_vec_t core_out_i,
  input  wire pad_pkg::pad_vec_t core_oe_i,
  output pad_pkg::pad_vec_t      core_in_o,
  // TAP side
  output logic                   tap_tck_o,
  output logic                   tap_tms_o,
  output logic                   tap_tdi_o,
  output logic                   tap_trst_n_o,
  input  wire logic              tap_tdo_i,
  input  wire logic              tap_tdo_oe_i,
  output logic                   jtag_active_o
);

  import pad_pkg::*;

  // Every pin the TAP owns while active
  localparam pad_vec_t JTAG_PINS = pad_vec_t'(
      (1 << `CHIP_PIN_TRST) | (1 << `CHIP_PIN_TCK) | (1 << `CHIP_PIN_TMS) |
      (1 << `CHIP_PIN_TDI)  | (1 << `CHIP_PIN_TDO));

  logic jtag_en_q;

  //////////////////////////////////////////////////////////////////////
  // Strap latch
  //////////////////////////////////////////////////////////////////////

  // Transparent while in reset, frozen once reset drops
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      jtag_en_q <= ring_in_i[`CHIP_PIN_JTAG_EN];
    end
  end

  assign jtag_active_o = jtag_en_q;

  //////////////////////////////////////////////////////////////////////
  // Pin routing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Plain pass-through, TAP parked in reset
    ring_out_o   = core_out_i;
    ring_oe_o    = core_oe_i;
    core_in_o    = ring_in_i;
    tap_tck_o    = 1'b0;
    tap_tms_o    = 1'b1;
    tap_tdi_o    = 1'b0;
    tap_trst_n_o = 1'b0;

    if (jtag_en_q) begin
      ring_oe_o                   = core_oe_i & ~JTAG_PINS;
      ring_oe_o[`CHIP_PIN_TDO]    = 1'b1;
      ring_out_o[`CHIP_PIN_TDO]   = tap_tdo_i & tap_tdo_oe_i;  // Idle low outside shift
      core_in_o = (ring_in_i & ~JTAG_PINS) | (`CHIP_JTAG_TIEOFF & JTAG_PINS);
      tap_tck_o    = ring_in_i[`CHIP_PIN_TCK];
      tap_tms_o    = ring_in_i[`CHIP_PIN_TMS];
      tap_tdi_o    = ring_in_i[`CHIP_PIN_TDI];
      tap_trst_n_o = ring_in_i[`CHIP_PIN_TRST];
    end
  end

  a_tdo_driven: assert property (
    @(posedge clk_i) disable iff (rst_i)
    jtag_active_o |-> ring_oe_o[`CHIP_PIN_TDO]
  ) else $error("jtag_overlay_mux: TDO not driven while JTAG active");

endmodule : jtag_overlay_mux

`default_nettype wire

/* design/jtag_pkg.sv */
/* JTAG types
   TAP controller states, instruction register type and instruction codes */

`default_nettype none

package jtag_pkg;

  // IEEE 1149.1 TAP controller states
  typedef enum logic [3:0] {
    TEST_LOGIC_RESET,
    RUN_TEST_IDLE,
    SELECT_DR_SCAN,
    CAPTURE_DR,
    SHIFT_DR,
    EXIT1_DR,
    PAUSE_DR,
    EXIT2_DR,
    UPDATE_DR,
    SELECT_IR_SCAN,
    CAPTURE_IR,
    SHIFT_IR,
    EXIT1_IR,
    PAUSE_IR,
    EXIT2_IR,
    UPDATE_IR
  } tap_state_e;

  typedef logic [3:0]  jtag_ir_t;
  typedef logic [31:0] idcode_t;

  // Instruction codes, anything unlisted behaves as BYPASS
  localparam jtag_ir_t INSTR_IDCODE = 4'h1;
  localparam jtag_ir_t INSTR_SAMPLE = 4'h2;
  localparam jtag_ir_t INSTR_BYPASS = 4'hf;

endpackage : jtag_pkg

`default_nettype wire

/* design/jtag_tap.sv */
/* JTAG TAP controller
   Oversampled TCK, IEEE state machine, IDCODE, SAMPLE and BYPASS registers */

`timescale 1ns/1ps
`default_nettype none

`include "chip_io_config.svh"

module jtag_tap (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire logic              tck_i,     // Already synchronized in the padring
  input  wire logic              tms_i,
  input  wire logic              tdi_i,
  input  wire logic              trst_n_i,
  input  wire pad_pkg::pad_vec_t sample_i,  // Core-side pad inputs
  output logic                   tdo_o,
  output logic                   tdo_oe_o
);

  import jtag_pkg::*;

  logic       tck_q;
  logic       tck_rise;
  logic       tck_fall;
  tap_state_e state_q;
  tap_state_e state_d;
  jtag_ir_t   ir_q;
  jtag_ir_t   ir_shift_q;
  idcode_t    dr_q;
  idcode_t    dr_shifted;
  idcode_t    dr_capture;

  //////////////////////////////////////////////////////////////////////
  // TCK edge detection
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tck_q <= 1'b0;
    end else begin
      tck_q <= tck_i;
    end
  end

  assign tck_rise = tck_i & ~tck_q;
  assign tck_fall = ~tck_i & tck_q;

  //////////////////////////////////////////////////////////////////////
  // TAP state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (state_q)
      TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   state_d = tms_i ? SELECT_IR_SCAN   : CAPTURE_DR;
      CAPTURE_DR:       state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
      SHIFT_DR:         state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
      EXIT1_DR:         state_d = tms_i ? UPDATE_DR        : PAUSE_DR;
      PAUSE_DR:         state_d = tms_i ? EXIT2_DR         : PAUSE_DR;
      EXIT2_DR:         state_d = tms_i ? UPDATE_DR        : SHIFT_DR;
      UPDATE_DR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
      SHIFT_IR:         state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
      EXIT1_IR:         state_d = tms_i ? UPDATE_IR        : PAUSE_IR;
      PAUSE_IR:         state_d = tms_i ? EXIT2_IR         : PAUSE_IR;
      EXIT2_IR:         state_d = tms_i ? UPDATE_IR        : SHIFT_IR;
      UPDATE_IR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      default:          state_d = TEST_LOGIC_RESET;
    endcase
  end

  // Five TMS-high rises reach TEST_LOGIC_RESET from anywhere
  always_ff @(posedge clk_i) begin
    if (rst_i || !trst_n_i) begin
      state_q <= TEST_LOGIC_RESET;
      ir_q    <= INSTR_IDCODE;
    end else if (tck_rise) begin
      state_q <= state_d;
      if (state_q == TEST_LOGIC_RESET) begin
        ir_q <= INSTR_IDCODE;
      end else if (state_q == UPDATE_IR) begin
        ir_q <= ir_shift_q;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data and instruction shift registers
  //////////////////////////////////////////////////////////////////////

  // Shift length follows the selected register, LSB out first
  always_comb begin
    dr_shifted = {1'b0, dr_q[31:1]};
    dr_capture = '0;  // BYPASS captures a single 0
    case (ir_q)
      INSTR_IDCODE: begin
        dr_shifted[31] = tdi_i;
        dr_capture     = `CHIP_JTAG_IDCODE;
      end
      INSTR_SAMPLE: begin
        dr_shifted[`CHIP_NUM_IO-1] = tdi_i;
        dr_capture                 = idcode_t'(sample_i);
      end
      default: dr_shifted[0] = tdi_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      case (state_q)
        CAPTURE_DR: dr_q       <= dr_capture;
        SHIFT_DR:   dr_q       <= dr_shifted;
        CAPTURE_IR: ir_shift_q <= jtag_ir_t'(1);
        SHIFT_IR:   ir_shift_q <= {tdi_i, ir_shift_q[3:1]};
        default: ;
      endcase
    end
  end

  // TDO launches on the falling edge
  always_ff @(posedge clk_i) begin
    if (rst_i || !trst_n_i) begin
      tdo_o    <= 1'b0;
      tdo_oe_o <= 1'b0;
    end else if (tck_fall) begin
      tdo_oe_o <= (state_q == SHIFT_DR) || (state_q == SHIFT_IR);
      tdo_o    <= (state_q == SHIFT_IR) ? ir_shift_q[0] : dr_q[0];
    end
  end

  a_trst_resets: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !trst_n_i |=> state_q == TEST_LOGIC_RESET
  ) else $error("jtag_tap: TRST did not reset the state machine");

endmodule : jtag_tap

`default_nettype wire

/* design/pad_pkg.sv */
/* Pad types
   Vector and register address types shared by the padring, mux and GPIO core */

`default_nettype none

`include "chip_io_config.svh"

package pad_pkg;

  //////////////////////////////////////////////////////////////////////
  // Pad vectors
  //////////////////////////////////////////////////////////////////////

  // One bit per pad, MIO in the low bits, DIO above
  // Also carries the per-pad inversion attribute
  typedef logic [`CHIP_NUM_IO-1:0] pad_vec_t;

  //////////////////////////////////////////////////////////////////////
  // Register port
  //////////////////////////////////////////////////////////////////////

  // Selects OUT, OE, INV or IN
  typedef logic [1:0] reg_addr_t;

endpackage : pad_pkg

`default_nettype wire

/* design/padring.sv */
/* Padring
   Per-pad inversion, connect masking and input synchronization */

`timescale 1ns/1ps
`default_nettype none

`include "chip_io_config.svh"

module padring (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  // Pad side
  input  wire pad_pkg::pad_vec_t pad_in_i,
  output pad_pkg::pad_vec_t      pad_out_o,
  output pad_pkg::pad_vec_t      pad_oe_o,
  // Core side
  input  wire pad_pkg::pad_vec_t ring_out_i,
  input  wire pad_pkg::pad_vec_t ring_oe_i,
  output pad_pkg::pad_vec_t      ring_in_o,
  // Attributes
  input  wire pad_pkg::pad_vec_t inv_i
);

  import pad_pkg::*;

  pad_vec_t sync_q [`CHIP_TCK_SYNC];

  //////////////////////////////////////////////////////////////////////
  // Output path
  //////////////////////////////////////////////////////////////////////

  assign pad_out_o = ring_out_i ^ inv_i;
  assign pad_oe_o  = ring_oe_i & `CHIP_IO_CONNECT;  // Unbonded pads never drive

  //////////////////////////////////////////////////////////////////////
  // Input path
  //////////////////////////////////////////////////////////////////////

  // Pads are asynchronous to clk_i, TCK included
  always_ff @(posedge clk_i) begin
    sync_q[0] <= pad_in_i & `CHIP_IO_CONNECT;
    for (int i = 1; i < `CHIP_TCK_SYNC; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  // Inversion after the synchronizer
  assign ring_in_o = (sync_q[`CHIP_TCK_SYNC-1] ^ inv_i) & `CHIP_IO_CONNECT;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_oe_connected: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (pad_oe_o & ~pad_vec_t'(`CHIP_IO_CONNECT)) == '0
  ) else $error("padring: output enable on unbonded pad");

endmodule : padring

`default_nettype wire

/* tb.f */
+incdir+design
design/pad_pkg.sv
design/jtag_pkg.sv
design/padring.sv
design/jtag_overlay_mux.sv
design/jtag_tap.sv
design/gpio_core.sv
design/chip_io_top.sv
tb/tb_chip_io.sv

/* tb/tb_chip_io.sv */
/* Chip IO testbench
   Directed tests of the register port, pad paths, JTAG strap and TAP */

`timescale 1ns/1ps
`default_nettype none

`include "chip_io_config.svh"

module tb_chip_io;

  import pad_pkg::*;
  import jtag_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int TCK_HALF    = 8;    // clk_i cycles per TCK phase
  localparam int JTAG_CLOCKS = 160;  // TCK periods over all tests
  localparam int REG_CYCLES  = 400;
  localparam int TIMEOUT_NS  = 2 * CLK_PERIOD * (JTAG_CLOCKS * 2 * TCK_HALF + REG_CYCLES);

  // Pins handed to the TAP while the strap is set
  localparam pad_vec_t JTAG_PINS = pad_vec_t'(
      (1 << `CHIP_PIN_TRST) | (1 << `CHIP_PIN_TCK) | (1 << `CHIP_PIN_TMS) |
      (1 << `CHIP_PIN_TDI)  | (1 << `CHIP_PIN_TDO));
  localparam pad_vec_t TDO_BIT = pad_vec_t'(1 << `CHIP_PIN_TDO);

  logic      clk;
  logic      rst;
  pad_vec_t  pad_in;
  pad_vec_t  pad_out;
  pad_vec_t  pad_oe;
  logic      reg_we;
  reg_addr_t reg_addr;
  pad_vec_t  reg_wdata;
  pad_vec_t  reg_rdata;
  logic      jtag_active;
  integer    seed;

  chip_io_top chip_io_top_i (
    .clk_i         ( clk         ),
    .rst_i         ( rst         ),
    .pad_in_i      ( pad_in      ),
    .pad_out_o     ( pad_out     ),
    .pad_oe_o      ( pad_oe      ),
    .reg_we_i      ( reg_we      ),
    .reg_addr_i    ( reg_addr    ),
    .reg_wdata_i   ( reg_wdata   ),
    .reg_rdata_o   ( reg_rdata   ),
    .jtag_active_o ( jtag_active )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] expected,
                       input string message);
    if (got !== expected) begin
      $display("[ERROR] %0t ns: %s (got %h, expected %h)", $time, message, got, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic pad_vec_t rand_pads();
    return pad_vec_t'($random(seed));
  endfunction

  // What the core should read with inverted pads and stolen pins tied off
  function automatic pad_vec_t core_view(input pad_vec_t pads, input pad_vec_t inv,
                                         input logic active);
    pad_vec_t v;
    v = (pads ^ inv) & `CHIP_IO_CONNECT;
    if (active) begin
      v = (v & ~JTAG_PINS) | (`CHIP_JTAG_TIEOFF & JTAG_PINS);
    end
    return v;
  endfunction

  task automatic apply_reset(input logic strap);
    @(negedge clk);
    rst       = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = `REG_OUT;
    reg_wdata = '0;
    pad_in    = '0;
    pad_in[`CHIP_PIN_JTAG_EN] = strap;
    pad_in[`CHIP_PIN_TRST]    = 1'b1;  // TRST released and TMS parked high
    pad_in[`CHIP_PIN_TMS]     = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic reg_write(input reg_addr_t addr, input pad_vec_t data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we    = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output pad_vec_t data);
    @(negedge clk);
    reg_addr = addr;
    #1;
    data = reg_rdata;
  endtask

  // One TCK period starting with the low phase
  task automatic jtag_clock(input logic tms, input logic tdi, output logic tdo);
    @(negedge clk);
    pad_in[`CHIP_PIN_TCK] = 1'b0;
    pad_in[`CHIP_PIN_TMS] = tms;
    pad_in[`CHIP_PIN_TDI] = tdi;
    repeat (TCK_HALF) @(negedge clk);
    tdo = pad_out[`CHIP_PIN_TDO];  // Just before TCK rises
    pad_in[`CHIP_PIN_TCK] = 1'b1;
    repeat (TCK_HALF - 1) @(negedge clk);
  endtask

  task automatic tms_reset();
    logic unused;
    repeat (5) jtag_clock(1'b1, 1'b0, unused);
    jtag_clock(1'b0, 1'b0, unused);  // RUN_TEST_IDLE
  endtask

  task automatic jtag_shift_ir(input jtag_ir_t instr, output jtag_ir_t captured);
    logic bit_out;
    jtag_clock(1'b1, 1'b0, bit_out);  // SELECT_DR_SCAN
    jtag_clock(1'b1, 1'b0, bit_out);  // SELECT_IR_SCAN
    jtag_clock(1'b0, 1'b0, bit_out);  // CAPTURE_IR
    jtag_clock(1'b0, 1'b0, bit_out);  // SHIFT_IR
    for (int i = 0; i < $bits(jtag_ir_t); i++) begin
      jtag_clock(i == $bits(jtag_ir_t) - 1, instr[i], bit_out);
      captured[i] = bit_out;
    end
    jtag_clock(1'b1, 1'b0, bit_out);  // UPDATE_IR
    jtag_clock(1'b0, 1'b0, bit_out);  // RUN_TEST_IDLE with the new IR live
  endtask

  task automatic jtag_shift_dr(input logic [31:0] data_in, input int len,
                               output logic [31:0] data_out);
    logic bit_out;
    jtag_clock(1'b1, 1'b0, bit_out);  // SELECT_DR_SCAN
    jtag_clock(1'b0, 1'b0, bit_out);  // CAPTURE_DR
    jtag_clock(1'b0, 1'b0, bit_out);  // SHIFT_DR
    data_out = '0;
    for (int i = 0; i < len; i++) begin
      jtag_clock(i == len - 1, data_in[i], bit_out);
      data_out[i] = bit_out;
    end
    jtag_clock(1'b1, 1'b0, bit_out);  // UPDATE_DR
    jtag_clock(1'b0, 1'b0, bit_out);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    pad_vec_t got;
    apply_reset(1'b0);
    check(32'(pad_oe), 32'd0, "pad_oe_o after reset");
    check(32'(jtag_active), 32'd0, "jtag_active_o with strap low");
    reg_read(`REG_OUT, got);
    check(32'(got), 32'd0, "OUT after reset");
    reg_read(`REG_OE, got);
    check(32'(got), 32'd0, "OE after reset");
    reg_read(`REG_INV, got);
    check(32'(got), 32'd0, "INV after reset");
  endtask

  task automatic output_path();
    pad_vec_t out_v;
    pad_vec_t oe_v;
    pad_vec_t inv_v;
    pad_vec_t got;
    repeat (8) begin
      out_v = rand_pads();
      oe_v  = rand_pads();
      inv_v = rand_pads();
      reg_write(`REG_OUT, out_v);
      reg_write(`REG_OE, oe_v);
      check(32'(pad_oe), 32'(oe_v), "pad_oe_o follows OE");
      reg_write(`REG_INV, inv_v);
      check(32'(pad_out), 32'(out_v ^ inv_v), "pad_out_o is OUT xor INV");
      reg_read(`REG_OUT, got);
      check(32'(got), 32'(out_v), "OUT read back");
      reg_read(`REG_INV, got);
      check(32'(got), 32'(inv_v), "INV read back");
    end
  endtask

  task automatic input_path();
    pad_vec_t inv_v;
    pad_vec_t pads;
    pad_vec_t got;
    repeat (8) begin
      inv_v = rand_pads();
      pads  = rand_pads();
      reg_write(`REG_INV, inv_v);
      pad_in = pads;
      repeat (2) @(posedge clk);  // Synchronizer depth
      reg_read(`REG_IN, got);
      check(32'(got), 32'(core_view(pads, inv_v, 1'b0)), "REG_IN after two cycles");
    end
  endtask

  task automatic strap_select();
    pad_vec_t inv_v;
    pad_vec_t pads;
    pad_vec_t oe_v;
    pad_vec_t got;
    apply_reset(1'b1);
    check(32'(jtag_active), 32'd1, "jtag_active_o with strap high");
    check(32'(pad_oe[`CHIP_PIN_TDO]), 32'd1, "TDO pad driven");
    inv_v = rand_pads() & ~JTAG_PINS;  // Keep TAP pins uninverted
    // Every JTAG pin opposite to its tie-off value
    pads  = (rand_pads() & ~JTAG_PINS) | (~pad_vec_t'(`CHIP_JTAG_TIEOFF) & JTAG_PINS);
    reg_write(`REG_INV, inv_v);
    pad_in = pads;
    repeat (2) @(posedge clk);
    reg_read(`REG_IN, got);
    check(32'(got), 32'(core_view(pads, inv_v, 1'b1)), "REG_IN with JTAG tie-offs");
    oe_v = rand_pads() | JTAG_PINS;
    reg_write(`REG_OE, oe_v);
    check(32'(pad_oe), 32'((oe_v & ~JTAG_PINS) | TDO_BIT), "core OE on JTAG pins");
  endtask

  task automatic idcode_read();
    logic [31:0] dr_got;
    jtag_ir_t    ir_got;
    tms_reset();
    jtag_shift_dr(32'h0, 32, dr_got);
    check(dr_got, `CHIP_JTAG_IDCODE, "IDCODE after TMS reset");
    jtag_shift_ir(INSTR_IDCODE, ir_got);
    check(32'(ir_got), 32'd1, "IR capture value");
    jtag_shift_dr(32'hffff_ffff, 32, dr_got);
    check(dr_got, `CHIP_JTAG_IDCODE, "IDCODE after IR load");
  endtask

  task automatic sample_and_bypass();
    pad_vec_t    inv_v;
    pad_vec_t    pads;
    logic [31:0] dr_in;
    logic [31:0] dr_got;
    jtag_ir_t    ir_got;
    inv_v = rand_pads() & ~JTAG_PINS;
    pads  = (rand_pads() & ~JTAG_PINS) | (pad_in & JTAG_PINS);
    reg_write(`REG_INV, inv_v);
    pad_in = pads;
    jtag_shift_ir(INSTR_SAMPLE, ir_got);
    check(32'(ir_got), 32'd1, "IR capture before SAMPLE");
    jtag_shift_dr(32'h0, `CHIP_NUM_IO, dr_got);
    check(dr_got, 32'(core_view(pads, inv_v, 1'b1)), "SAMPLE of core-side inputs");

    // Single-bit register returns the pattern one TCK late
    jtag_shift_ir(INSTR_BYPASS, ir_got);
    dr_in = $random(seed) & 32'h0000_ffff;
    jtag_shift_dr(dr_in, 16, dr_got);
    check(dr_got, (dr_in << 1) & 32'h0000_ffff, "BYPASS delay");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed      = 32'h73f90a47;
    rst       = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = `REG_OUT;
    reg_wdata = '0;
    pad_in    = '0;
    reset_state();
    output_path();
    input_path();
    strap_select();
    idcode_read();
    sample_and_bypass();
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule : tb_chip_io

`default_nettype wire
